// File: mini_pipe.f
source/pipe_pkg.sv
source/reg_file.sv
source/hazard_detect.sv
source/operand_forward.sv
source/alu.sv
source/data_mem.sv
source/mini_pipe.sv
test/wb_checker.sv
test/mini_pipe_asserts.sv
test/mini_pipe_tb.sv

// File: Bender.yml
package:
  name: mini_pipe

sources:
  - source/pipe_pkg.sv
  - source/reg_file.sv
  - source/hazard_detect.sv
  - source/operand_forward.sv
  - source/alu.sv
  - source/data_mem.sv
  - source/mini_pipe.sv
  - target: test
    files:
      - test/wb_checker.sv
      - test/mini_pipe_asserts.sv
      - test/mini_pipe_tb.sv

// File: test/mini_pipe_tb.sv
`timescale 1ns/1ps
`default_nettype none

module mini_pipe_tb;

    localparam int n_directed     = 21;
    localparam int n_rows         = 40;
    localparam int timeout_cycles = n_rows * 10 + 100;

    logic                            clk;
    logic                            reset;
    logic                            instr_valid;
    pipe_pkg::instr_t                instr;
    logic                            ready;
    logic                            wb_valid;
    logic [pipe_pkg::reg_addr_w-1:0] wb_rd;
    logic [pipe_pkg::xlen-1:0]       wb_data;

    // one row per instruction, the word and then the expected writeback
    logic [31:0] tbl_word  [0:n_rows-1];
    logic        tbl_we    [0:n_rows-1];
    logic [4:0]  tbl_rd    [0:n_rows-1];
    logic [31:0] tbl_val   [0:n_rows-1];
    int          tbl_stall [0:n_rows-1];

    integer seed;
    int     waits;
    int     errors;
    int     total;

    mini_pipe dut_i (
        .clk(clk), .reset(reset), .instr_valid(instr_valid), .instr(instr),
        .ready(ready), .wb_valid(wb_valid), .wb_rd(wb_rd), .wb_data(wb_data)
    );

    wb_checker chk_i (
        .clk(clk), .reset(reset), .wb_valid(wb_valid), .wb_rd(wb_rd), .wb_data(wb_data)
    );

    always #4 clk = ~clk;

    function automatic logic [31:0] rtype_word(input logic [6:0] f7, input logic [2:0] f3,
                                               input int rd, input int rs1, input int rs2);
        return {f7, rs2[4:0], rs1[4:0], f3, rd[4:0], pipe_pkg::op_rtype};
    endfunction

    function automatic logic [31:0] addi_word(input int rd, input int rs1, input int imm);
        return {imm[11:0], rs1[4:0], pipe_pkg::f3_add, rd[4:0], pipe_pkg::op_itype_alu};
    endfunction

    // word accesses use funct3 010
    function automatic logic [31:0] load_word(input int rd, input int rs1, input int imm);
        return {imm[11:0], rs1[4:0], 3'b010, rd[4:0], pipe_pkg::op_load};
    endfunction

    function automatic logic [31:0] store_word(input int rs2, input int rs1, input int imm);
        return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], pipe_pkg::op_store};
    endfunction

    task automatic put_row(input int idx, input logic [31:0] word, input int we, input int rd,
                           input logic [31:0] val);
        tbl_word[idx] = word;
        tbl_we[idx]   = (we != 0);
        tbl_rd[idx]   = rd[4:0];
        tbl_val[idx]  = val;
    endtask

    task automatic load_directed();
        // forward from execute, then two writers of x3 where the newer one wins
        put_row(0, addi_word(1, 0, 5), 1, 1, 32'd5);
        put_row(1, rtype_word(7'd0, pipe_pkg::f3_add, 2, 1, 1), 1, 2, 32'd10);
        put_row(2, addi_word(3, 0, 7), 1, 3, 32'd7);
        put_row(3, addi_word(3, 0, 9), 1, 3, 32'd9);
        put_row(4, rtype_word(7'd0, pipe_pkg::f3_add, 4, 3, 2), 1, 4, 32'd19);
        // x5 at distance two, x6 at distance one
        put_row(5, addi_word(5, 0, 100), 1, 5, 32'd100);
        put_row(6, addi_word(6, 0, 3), 1, 6, 32'd3);
        put_row(7, rtype_word(pipe_pkg::f7_sub, pipe_pkg::f3_add, 7, 5, 6), 1, 7, 32'd97);
        // store and load of word 2, then a load-use on rs1
        put_row(8, store_word(7, 0, 8), 0, 0, 32'd0);
        put_row(9, load_word(1, 0, 8), 1, 1, 32'd97);
        put_row(10, rtype_word(7'd0, pipe_pkg::f3_add, 2, 1, 4), 1, 2, 32'd116);
        put_row(11, rtype_word(7'd0, pipe_pkg::f3_and, 3, 2, 7), 1, 3, 32'd96);
        put_row(12, rtype_word(7'd0, pipe_pkg::f3_or, 4, 3, 6), 1, 4, 32'd99);
        // x0 as a destination is silent and reads back as zero
        put_row(13, addi_word(0, 0, 55), 0, 0, 32'd0);
        put_row(14, rtype_word(7'd0, pipe_pkg::f3_add, 0, 1, 2), 0, 0, 32'd0);
        put_row(15, rtype_word(7'd0, pipe_pkg::f3_add, 5, 0, 4), 1, 5, 32'd99);
        put_row(16, load_word(0, 0, 8), 0, 0, 32'd0);
        put_row(17, addi_word(6, 0, 1), 1, 6, 32'd1);
        // load-use on rs2
        put_row(18, load_word(2, 0, 8), 1, 2, 32'd97);
        put_row(19, rtype_word(pipe_pkg::f7_sub, pipe_pkg::f3_add, 6, 6, 2), 1, 6, 32'hffffffa0);
        put_row(20, addi_word(7, 6, -16), 1, 7, 32'hffffff90);
    endtask

    task automatic fill_random();
        int kind;
        int rd;
        int rs1;
        int rs2;
        int imm;
        for (int r = n_directed; r < n_rows; r++) begin
            kind = $unsigned($random(seed)) % 7;
            rd   = $unsigned($random(seed)) % 8;
            rs1  = $unsigned($random(seed)) % 8;
            rs2  = $unsigned($random(seed)) % 8;
            imm  = $random(seed);
            case (kind)
                0: tbl_word[r] = rtype_word(7'd0, pipe_pkg::f3_add, rd, rs1, rs2);
                1: tbl_word[r] = rtype_word(pipe_pkg::f7_sub, pipe_pkg::f3_add, rd, rs1, rs2);
                2: tbl_word[r] = rtype_word(7'd0, pipe_pkg::f3_and, rd, rs1, rs2);
                3: tbl_word[r] = rtype_word(7'd0, pipe_pkg::f3_or, rd, rs1, rs2);
                4: tbl_word[r] = addi_word(rd, rs1, imm);
                // byte addresses 0 to 252 off x0
                5: tbl_word[r] = load_word(rd, 0, (imm & 63) * 4);
                default: tbl_word[r] = store_word(rs2, 0, (imm & 63) * 4);
            endcase
        end
    endtask

    // executes the whole table in order, fills the random rows and every stall count
    task automatic run_model();
        logic [31:0] regs [0:31];
        logic [31:0] ram  [0:63];
        logic [31:0] w;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] val;
        logic [31:0] addr;
        logic [6:0]  opc;
        logic [4:0]  rd;
        logic        we;
        logic        uses_b;
        logic        prev_load;
        logic [4:0]  prev_rd;
        for (int k = 0; k < 32; k++) begin
            regs[k] = '0;
        end
        for (int k = 0; k < 64; k++) begin
            ram[k] = '0;
        end
        prev_load = 1'b0;
        prev_rd   = '0;
        for (int r = 0; r < n_rows; r++) begin
            w      = tbl_word[r];
            opc    = w[6:0];
            rd     = w[11:7];
            a      = regs[w[19:15]];
            b      = regs[w[24:20]];
            we     = (rd != '0);
            val    = '0;
            uses_b = (opc == pipe_pkg::op_rtype) || (opc == pipe_pkg::op_store);
            case (opc)
                pipe_pkg::op_rtype: begin
                    val = (w[14:12] == pipe_pkg::f3_and) ? (a & b) :
                          (w[14:12] == pipe_pkg::f3_or)  ? (a | b) :
                          (w[31:25] == pipe_pkg::f7_sub) ? (a - b) : (a + b);
                end
                pipe_pkg::op_itype_alu: begin
                    val = a + {{20{w[31]}}, w[31:20]};
                end
                pipe_pkg::op_load: begin
                    addr = a + {{20{w[31]}}, w[31:20]};
                    val  = ram[addr[7:2]];
                end
                default: begin
                    addr = a + {{20{w[31]}}, w[31:25], w[11:7]};
                    ram[addr[7:2]] = b;
                    we = 1'b0;
                end
            endcase
            if (we) begin
                regs[rd] = val;
            end
            // a load directly ahead whose destination is read here costs one cycle
            tbl_stall[r] = (prev_load && (prev_rd != '0) &&
                            ((w[19:15] == prev_rd) || (uses_b && (w[24:20] == prev_rd)))) ? 1 : 0;
            if (r >= n_directed) begin
                tbl_we[r]  = we;
                tbl_rd[r]  = rd;
                tbl_val[r] = val;
            end
            prev_load = (opc == pipe_pkg::op_load);
            prev_rd   = rd;
        end
    endtask

    initial begin
        clk         = 1'b0;
        reset       = 1'b0;
        instr_valid = 1'b0;
        instr       = '0;
        seed        = 32'heea8;
        errors      = 0;
        load_directed();
        fill_random();
        run_model();
        repeat (8) @(posedge clk);
        #1;
        reset = 1'b1;
        for (int r = 0; r < n_rows; r++) begin
            instr       = tbl_word[r];
            instr_valid = 1'b1;
            waits       = 0;
            #1;
            // the word stays on the bus until ready comes back
            while (!ready) begin
                waits++;
                @(posedge clk);
                #2;
            end
            @(posedge clk);
            #1;
            if (tbl_we[r]) begin
                chk_i.expect_write(r, tbl_rd[r], tbl_val[r]);
            end
            if (waits != tbl_stall[r]) begin
                $display("[ERROR] %0t ns: ready low for %0d cycles at row %0d, expected %0d",
                         $time, waits, r, tbl_stall[r]);
                errors++;
            end
        end
        instr_valid = 1'b0;
        // the last accepted word reaches writeback two edges after acceptance
        repeat (3) @(posedge clk);
        #1;
        if (chk_i.pending() != 0) begin
            $display("%0d expected writebacks never reached the writeback port", chk_i.pending());
            errors++;
        end
        total = errors + chk_i.error_count + dut_i.asserts_i.fail_count;
        $display("%0d rows issued, %0d writebacks checked, %0d errors",
                 n_rows, chk_i.check_count, total);
        if (total == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

    // bound on the run, scaled by the table length
    initial begin
        repeat (timeout_cycles) @(posedge clk);
        $display("pipeline hung, the run did not finish within %0d cycles", timeout_cycles);
        $display("tests failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: test/mini_pipe_asserts.sv
`timescale 1ns/1ps
`default_nettype none

module mini_pipe_asserts (
    input wire                             clk,
    input wire                             reset,
    input wire                             ready,
    input wire                             wb_valid,
    input wire [pipe_pkg::reg_addr_w-1:0]  wb_rd
);

    int fail_count;

    initial begin
        fail_count = 0;
    end

    // x0 never shows up on the writeback port
    no_wb_to_x0: assert property (@(posedge clk) disable iff (!reset)
                                  wb_valid |-> (wb_rd != '0))
        else begin
            $error("writeback reported for x0");
            fail_count++;
        end

    // a load-use stall lasts one cycle only
    single_stall: assert property (@(posedge clk) disable iff (!reset) !ready |=> ready)
        else begin
            $error("ready stayed low for two cycles in a row");
            fail_count++;
        end

    quiet_in_reset: assert property (@(posedge clk) !reset |-> !wb_valid)
        else begin
            $error("wb_valid high while reset is asserted");
            fail_count++;
        end

endmodule

bind mini_pipe mini_pipe_asserts asserts_i (
    .clk(clk), .reset(reset), .ready(ready), .wb_valid(wb_valid), .wb_rd(wb_rd)
);

`default_nettype wire

// File: test/wb_checker.sv
`timescale 1ns/1ps
`default_nettype none

module wb_checker (
    input wire                             clk,
    input wire                             reset,
    input wire                             wb_valid,
    input wire [pipe_pkg::reg_addr_w-1:0]  wb_rd,
    input wire [pipe_pkg::xlen-1:0]        wb_data
);

    // expected writebacks in issue order
    int                              exp_row_q  [$];
    int                              exp_cyc_q  [$];
    logic [pipe_pkg::reg_addr_w-1:0] exp_rd_q   [$];
    logic [pipe_pkg::xlen-1:0]       exp_data_q [$];

    int                              check_count;
    int                              error_count;
    int                              cycle_count;
    int                              exp_row;
    int                              exp_cyc;
    logic [pipe_pkg::reg_addr_w-1:0] exp_rd;
    logic [pipe_pkg::xlen-1:0]       exp_data;
    logic                            row_ok;

    initial begin
        check_count = 0;
        error_count = 0;
        cycle_count = 0;
    end

    // called just after the accepting edge, which cycle_count already includes
    task automatic expect_write(input int row, input logic [pipe_pkg::reg_addr_w-1:0] rd,
                                input logic [pipe_pkg::xlen-1:0] data);
        exp_row_q.push_back(row);
        exp_cyc_q.push_back(cycle_count);
        exp_rd_q.push_back(rd);
        exp_data_q.push_back(data);
    endtask

    function automatic int pending();
        return exp_row_q.size();
    endfunction

    // writeback outputs are registered, so the edge sees the finished cycle
    // the result shows up two edges after the accepting edge
    always @(posedge clk) begin
        if (reset && wb_valid) begin
            if (exp_row_q.size() == 0) begin
                $display("writeback to x%0d at %0t ns with no instruction waiting for one",
                         wb_rd, $time);
                error_count++;
            end else begin
                exp_row  = exp_row_q.pop_front();
                exp_cyc  = exp_cyc_q.pop_front();
                exp_rd   = exp_rd_q.pop_front();
                exp_data = exp_data_q.pop_front();
                row_ok   = 1'b1;
                check_count++;
                if (cycle_count != exp_cyc + 2) begin
                    $display("[ERROR] %0t ns: wb_valid expected in cycle %0d, got cycle %0d",
                             $time, exp_cyc + 2, cycle_count);
                    row_ok = 1'b0;
                end
                if (wb_rd !== exp_rd) begin
                    $display("[ERROR] %0t ns: wb_rd expected %0d, got %0d", $time, exp_rd, wb_rd);
                    row_ok = 1'b0;
                end
                if (wb_data !== exp_data) begin
                    $display("[ERROR] %0t ns: wb_data expected 0x%08h, got 0x%08h",
                             $time, exp_data, wb_data);
                    row_ok = 1'b0;
                end
                if (row_ok) begin
                    $display("row %0d: x%0d = 0x%08h ok", exp_row, exp_rd, exp_data);
                end else begin
                    $display("row %0d: writeback mismatch", exp_row);
                    error_count++;
                end
            end
        end
        cycle_count++;
    end

endmodule

`default_nettype wire

// File: source/mini_pipe.sv
`timescale 1ns/1ps
`default_nettype none

module mini_pipe (
    input  wire                              clk,
    input  wire                              reset,
    input  wire                              instr_valid,
    input  wire pipe_pkg::instr_t            instr,
    output logic                             ready,
    output logic                             wb_valid,
    output logic [pipe_pkg::reg_addr_w-1:0]  wb_rd,
    output logic [pipe_pkg::xlen-1:0]        wb_data
);

    logic                            accept;
    logic                            stall;
    logic [1:0]                      fwd_a;
    logic [1:0]                      fwd_b;
    logic [pipe_pkg::xlen-1:0]       rdata_a;
    logic [pipe_pkg::xlen-1:0]       rdata_b;
    logic [pipe_pkg::xlen-1:0]       op_a;
    logic [pipe_pkg::xlen-1:0]       op_b;
    logic [pipe_pkg::xlen-1:0]       alu_result;
    logic [pipe_pkg::xlen-1:0]       store_data;
    logic [pipe_pkg::xlen-1:0]       mem_result;

    // execute stage
    pipe_pkg::instr_t                ex_instr;
    logic                            ex_valid;
    logic                            ex_writes;
    logic                            ex_is_load;
    logic [pipe_pkg::reg_addr_w-1:0] ex_rd;

    // memory stage
    pipe_pkg::instr_t                mem_instr;
    logic                            mem_valid;
    logic                            mem_writes;
    logic [pipe_pkg::reg_addr_w-1:0] mem_rd;
    logic [pipe_pkg::xlen-1:0]       mem_alu;
    logic [pipe_pkg::xlen-1:0]       mem_store_data;

    assign ready  = ~stall;
    assign accept = instr_valid && ready;

    // stores leave rd as zero so they never match a source
    assign ex_writes  = (ex_instr.r.opcode == pipe_pkg::op_rtype) ||
                        (ex_instr.r.opcode == pipe_pkg::op_itype_alu) ||
                        (ex_instr.r.opcode == pipe_pkg::op_load);
    assign ex_is_load = ex_valid && (ex_instr.r.opcode == pipe_pkg::op_load);
    assign ex_rd      = ex_writes ? ex_instr.r.rd : '0;

    assign mem_writes = (mem_instr.r.opcode == pipe_pkg::op_rtype) ||
                        (mem_instr.r.opcode == pipe_pkg::op_itype_alu) ||
                        (mem_instr.r.opcode == pipe_pkg::op_load);
    assign mem_rd     = mem_writes ? mem_instr.r.rd : '0;

    reg_file rf_i (
        .clk(clk), .reset(reset),
        .raddr_a(instr.r.rs1), .raddr_b(instr.r.rs2),
        .rdata_a(rdata_a), .rdata_b(rdata_b),
        .we(mem_valid && mem_writes), .waddr(mem_rd), .wdata(mem_result)
    );

    hazard_detect hz_i (
        .instr(instr), .instr_valid(instr_valid),
        .ex_valid(ex_valid), .ex_rd(ex_rd), .ex_is_load(ex_is_load),
        .mem_valid(mem_valid), .mem_rd(mem_rd),
        .fwd_a(fwd_a), .fwd_b(fwd_b), .stall(stall)
    );

    operand_forward fw_i (
        .clk(clk), .reset(reset), .accept(accept),
        .fwd_a(fwd_a), .fwd_b(fwd_b), .rdata_a(rdata_a), .rdata_b(rdata_b),
        .alu_result(alu_result), .mem_result(mem_result), .op_a(op_a), .op_b(op_b)
    );

    alu alu_i (
        .instr(ex_instr), .op_a(op_a), .op_b(op_b),
        .result(alu_result), .store_data(store_data)
    );

    data_mem dm_i (
        .clk(clk), .reset(reset), .instr(mem_instr), .valid(mem_valid),
        .addr(mem_alu), .store_data(mem_store_data), .alu_value(mem_alu),
        .mem_result(mem_result)
    );

    // a stalled or missing instruction turns into a bubble in execute
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            ex_valid  <= 1'b0;
            mem_valid <= 1'b0;
            wb_valid  <= 1'b0;
        end else begin
            ex_valid  <= accept;
            mem_valid <= ex_valid;
            wb_valid  <= mem_valid && mem_writes && (mem_rd != '0);
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            ex_instr <= instr;
        end
        mem_instr      <= ex_instr;
        mem_alu        <= alu_result;
        mem_store_data <= store_data;
        wb_rd          <= mem_rd;
        wb_data        <= mem_result;
    end

endmodule

`default_nettype wire

// File: source/data_mem.sv
`timescale 1ns/1ps
`default_nettype none

module data_mem (
    input  wire                          clk,
    input  wire                          reset,
    input  wire pipe_pkg::instr_t        instr,
    input  wire                          valid,
    input  wire  [pipe_pkg::xlen-1:0]    addr,
    input  wire  [pipe_pkg::xlen-1:0]    store_data,
    input  wire  [pipe_pkg::xlen-1:0]    alu_value,
    output logic [pipe_pkg::xlen-1:0]    mem_result
);

    logic [pipe_pkg::xlen-1:0]        ram [0:pipe_pkg::dmem_words-1];
    logic [pipe_pkg::dmem_addr_w-1:0] word_idx;
    logic                             is_load;
    logic                             is_store;

    // word addressed, low two bits ignored
    assign word_idx = addr[pipe_pkg::dmem_addr_w+1:2];
    assign is_load  = valid && (instr.r.opcode == pipe_pkg::op_load);
    assign is_store = valid && (instr.r.opcode == pipe_pkg::op_store);

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            for (int k = 0; k < pipe_pkg::dmem_words; k++) begin
                ram[k] <= '0;
            end
        end else if (is_store) begin
            ram[word_idx] <= store_data;
        end
    end

    // result of the memory stage, feeds forwarding and writeback
    always_comb begin
        if (is_load) begin
            mem_result = ram[word_idx];
        end else begin
            mem_result = alu_value;
        end
    end

endmodule

`default_nettype wire

// File: source/alu.sv
`timescale 1ns/1ps
`default_nettype none

module alu (
    input  wire pipe_pkg::instr_t          instr,
    input  wire  [pipe_pkg::xlen-1:0]      op_a,
    input  wire  [pipe_pkg::xlen-1:0]      op_b,
    output logic [pipe_pkg::xlen-1:0]      result,
    output logic [pipe_pkg::xlen-1:0]      store_data
);

    logic [pipe_pkg::xlen-1:0] imm_i;
    logic [pipe_pkg::xlen-1:0] imm_s;

    assign imm_i = {{(pipe_pkg::xlen - 12){instr.i.imm[11]}}, instr.i.imm};
    assign imm_s = {{(pipe_pkg::xlen - 12){instr.s.imm_hi[6]}}, instr.s.imm_hi, instr.s.imm_lo};

    always_comb begin
        case (instr.r.opcode)
            pipe_pkg::op_rtype: begin
                case (instr.r.funct3)
                    pipe_pkg::f3_and: result = op_a & op_b;
                    pipe_pkg::f3_or:  result = op_a | op_b;
                    default: begin
                        if (instr.r.funct7 == pipe_pkg::f7_sub) begin
                            result = op_a - op_b;
                        end else begin
                            result = op_a + op_b;
                        end
                    end
                endcase
            end
            // addi data and load address share the i immediate
            pipe_pkg::op_itype_alu, pipe_pkg::op_load: begin
                result = op_a + imm_i;
            end
            pipe_pkg::op_store: begin
                result = op_a + imm_s;
            end
            default: begin
                result = '0;
            end
        endcase
    end

    assign store_data = op_b;

endmodule

`default_nettype wire

// File: source/operand_forward.sv
`timescale 1ns/1ps
`default_nettype none

module operand_forward (
    input  wire                         clk,
    input  wire                         reset,
    input  wire                         accept,
    input  wire  [1:0]                  fwd_a,
    input  wire  [1:0]                  fwd_b,
    input  wire  [pipe_pkg::xlen-1:0]   rdata_a,
    input  wire  [pipe_pkg::xlen-1:0]   rdata_b,
    input  wire  [pipe_pkg::xlen-1:0]   alu_result,
    input  wire  [pipe_pkg::xlen-1:0]   mem_result,
    output logic [pipe_pkg::xlen-1:0]   op_a,
    output logic [pipe_pkg::xlen-1:0]   op_b
);

    logic [pipe_pkg::xlen-1:0] next_a;
    logic [pipe_pkg::xlen-1:0] next_b;

    // mem_result already carries the loaded word for a load,
    // otherwise the alu value passed down from execute
    always_comb begin
        case (fwd_a)
            pipe_pkg::fwd_ex: begin
                next_a = alu_result;
            end
            pipe_pkg::fwd_mem: begin
                next_a = mem_result;
            end
            default: begin
                next_a = rdata_a;
            end
        endcase
    end

    always_comb begin
        case (fwd_b)
            pipe_pkg::fwd_ex: begin
                next_b = alu_result;
            end
            pipe_pkg::fwd_mem: begin
                next_b = mem_result;
            end
            default: begin
                next_b = rdata_b;
            end
        endcase
    end

    // operands enter execute together with the instruction word
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            op_a <= '0;
            op_b <= '0;
        end else if (accept) begin
            op_a <= next_a;
            op_b <= next_b;
        end
    end

endmodule

`default_nettype wire

// File: source/hazard_detect.sv
`timescale 1ns/1ps
`default_nettype none

module hazard_detect (
    input  wire pipe_pkg::instr_t            instr,
    input  wire                              instr_valid,
    input  wire                              ex_valid,
    input  wire  [pipe_pkg::reg_addr_w-1:0]  ex_rd,
    input  wire                              ex_is_load,
    input  wire                              mem_valid,
    input  wire  [pipe_pkg::reg_addr_w-1:0]  mem_rd,
    output logic [1:0]                       fwd_a,
    output logic [1:0]                       fwd_b,
    output logic                             stall
);

    logic [6:0] opcode;
    logic       use_a;
    logic       use_b;
    logic       ex_hit_a;
    logic       ex_hit_b;

    // execute is newer than memory, so it is checked first
    function automatic logic [1:0] pick_src(
        input logic                       used,
        input logic [pipe_pkg::reg_addr_w-1:0] src,
        input logic                       ex_v,
        input logic [pipe_pkg::reg_addr_w-1:0] ex_d,
        input logic                       mem_v,
        input logic [pipe_pkg::reg_addr_w-1:0] mem_d
    );
        logic [1:0] sel;
        sel = pipe_pkg::fwd_none;
        if (used && (src != '0)) begin
            if (ex_v && (ex_d == src)) begin
                sel = pipe_pkg::fwd_ex;
            end else if (mem_v && (mem_d == src)) begin
                sel = pipe_pkg::fwd_mem;
            end
        end
        return sel;
    endfunction

    assign opcode = instr.r.opcode;

    // rs1 is read by every supported class, rs2 only by r-type and stores
    assign use_a = (opcode == pipe_pkg::op_rtype) || (opcode == pipe_pkg::op_itype_alu) ||
                   (opcode == pipe_pkg::op_load)  || (opcode == pipe_pkg::op_store);
    assign use_b = (opcode == pipe_pkg::op_rtype) || (opcode == pipe_pkg::op_store);

    assign fwd_a = pick_src(use_a, instr.r.rs1, ex_valid, ex_rd, mem_valid, mem_rd);
    assign fwd_b = pick_src(use_b, instr.r.rs2, ex_valid, ex_rd, mem_valid, mem_rd);

    assign ex_hit_a = (fwd_a == pipe_pkg::fwd_ex);
    assign ex_hit_b = (fwd_b == pipe_pkg::fwd_ex);

    // load data only exists in the memory stage, hold decode one cycle
    assign stall = instr_valid && ex_is_load && (ex_hit_a || ex_hit_b);

endmodule

`default_nettype wire

// File: source/reg_file.sv
`timescale 1ns/1ps
`default_nettype none

module reg_file (
    input  wire                              clk,
    input  wire                              reset,
    input  wire  [pipe_pkg::reg_addr_w-1:0]  raddr_a,
    input  wire  [pipe_pkg::reg_addr_w-1:0]  raddr_b,
    output logic [pipe_pkg::xlen-1:0]        rdata_a,
    output logic [pipe_pkg::xlen-1:0]        rdata_b,
    input  wire                              we,
    input  wire  [pipe_pkg::reg_addr_w-1:0]  waddr,
    input  wire  [pipe_pkg::xlen-1:0]        wdata
);

    logic [pipe_pkg::xlen-1:0] regs [0:(1 << pipe_pkg::reg_addr_w)-1];

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            for (int k = 0; k < (1 << pipe_pkg::reg_addr_w); k++) begin
                regs[k] <= '0;
            end
        end else if (we && (waddr != '0)) begin
            regs[waddr] <= wdata;
        end
    end

    // x0 reads as zero whatever the array holds
    // a write in this cycle is not visible until the next one
    always_comb begin
        if (raddr_a == '0) begin
            rdata_a = '0;
        end else begin
            rdata_a = regs[raddr_a];
        end
        if (raddr_b == '0) begin
            rdata_b = '0;
        end else begin
            rdata_b = regs[raddr_b];
        end
    end

endmodule

`default_nettype wire

// File: source/pipe_pkg.sv
`default_nettype none

package pipe_pkg;

    // datapath sizes
    localparam int xlen        = 32;
    localparam int reg_addr_w  = 5;
    localparam int dmem_words  = 64;
    localparam int dmem_addr_w = 6;

    // rv32i opcodes of the supported classes
    localparam logic [6:0] op_rtype     = 7'b0110011;
    localparam logic [6:0] op_itype_alu = 7'b0010011;
    localparam logic [6:0] op_load      = 7'b0000011;
    localparam logic [6:0] op_store     = 7'b0100011;

    localparam logic [2:0] f3_add = 3'b000;
    localparam logic [2:0] f3_and = 3'b111;
    localparam logic [2:0] f3_or  = 3'b110;

    // funct7 bit 5 set turns add into sub
    localparam logic [6:0] f7_sub = 7'b0100000;

    // operand source selects
    localparam logic [1:0] fwd_none = 2'd0;
    localparam logic [1:0] fwd_ex   = 2'd1;
    localparam logic [1:0] fwd_mem  = 2'd2;

    // one instruction word seen through the three formats
    typedef union packed {
        struct packed {
            logic [6:0]            funct7;
            logic [reg_addr_w-1:0] rs2;
            logic [reg_addr_w-1:0] rs1;
            logic [2:0]            funct3;
            logic [reg_addr_w-1:0] rd;
            logic [6:0]            opcode;
        } r;
        struct packed {
            logic [11:0]           imm;
            logic [reg_addr_w-1:0] rs1;
            logic [2:0]            funct3;
            logic [reg_addr_w-1:0] rd;
            logic [6:0]            opcode;
        } i;
        struct packed {
            logic [6:0]            imm_hi;
            logic [reg_addr_w-1:0] rs2;
            logic [reg_addr_w-1:0] rs1;
            logic [2:0]            funct3;
            logic [4:0]            imm_lo;
            logic [6:0]            opcode;
        } s;
    } instr_t;

endpackage

`default_nettype wire
